//--- include/issue_defines.svh
/* issue stage parameters */

`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// architectural register count, r0 reads zero
`define ISSUE_NREG 32

// width of one register word
`define ISSUE_DATA_W 32

// one FUST row per unit: alu, load/store, branch
`define ISSUE_NFU 3

// producer tag is fu index plus one, zero means register file
`define ISSUE_TAG_W 2

// dispatch order counter per row, saturating
`define ISSUE_AGE_W 2

`endif

//--- hw/issue_pkg.sv
/* issue stage types */

`include "issue_defines.svh"

package issue_pkg;

    // register index
    typedef logic [$clog2(`ISSUE_NREG)-1:0] regbits_t;

    // register data
    typedef logic [`ISSUE_DATA_W-1:0] word_t;

    // producer tag, zero when the operand sits in the register file
    typedef logic [`ISSUE_TAG_W-1:0] tag_t;

    // fu index: 0 alu, 1 ld/st, 2 branch
    typedef logic [$clog2(`ISSUE_NFU)-1:0] fu_idx_t;

    // row age in dispatch order
    typedef logic [`ISSUE_AGE_W-1:0] age_t;

    // per row issue state
    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

endpackage

//--- hw/regfile.sv
/* scalar register file */

`timescale 1ns/1ns
`include "issue_defines.svh"

module regfile (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                wen,
    input  issue_pkg::regbits_t wsel,
    input  issue_pkg::word_t    wdata,
    input  issue_pkg::regbits_t rsel1,
    input  issue_pkg::regbits_t rsel2,
    output issue_pkg::word_t    rdat1,
    output issue_pkg::word_t    rdat2
);

    issue_pkg::word_t [`ISSUE_NREG-1:0] regs;

    // r0 stays zero, writes to it are dropped
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '0;
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdata;
        end
    end

    // read port with same cycle write forwarding
    function automatic issue_pkg::word_t read_port(input issue_pkg::regbits_t sel);
        issue_pkg::word_t val;
        val = regs[sel];
        if (sel == '0) begin
            val = '0;
        end else if (wen && (wsel == sel)) begin
            val = wdata;
        end
        return val;
    endfunction

    always_comb begin
        rdat1 = read_port(rsel1);
        rdat2 = read_port(rsel2);
    end

endmodule

//--- hw/fust_table.sv
/* functional unit status table */

`timescale 1ns/1ns
`include "issue_defines.svh"

module fust_table (
    input  logic                                     CLK,
    input  logic                                     nRST,
    input  logic                                     disp_en,
    input  issue_pkg::fu_idx_t                       disp_fu,
    input  issue_pkg::regbits_t                      disp_rd,
    input  issue_pkg::regbits_t                      disp_rs1,
    input  issue_pkg::regbits_t                      disp_rs2,
    input  issue_pkg::tag_t                          disp_t1,
    input  issue_pkg::tag_t                          disp_t2,
    input  logic                                     disp_spec,
    input  logic                                     wb_en,
    input  issue_pkg::fu_idx_t                       wb_fu,
    input  issue_pkg::fust_state_e [`ISSUE_NFU-1:0]  state,
    input  logic [`ISSUE_NFU-1:0]                    flush_rows,
    output logic [`ISSUE_NFU-1:0]                    elig,
    output issue_pkg::regbits_t [`ISSUE_NFU-1:0]     row_rd,
    output issue_pkg::regbits_t [`ISSUE_NFU-1:0]     row_rs1,
    output issue_pkg::regbits_t [`ISSUE_NFU-1:0]     row_rs2,
    output logic [`ISSUE_NFU-1:0]                    spec
);

    issue_pkg::tag_t [`ISSUE_NFU-1:0] t1;
    issue_pkg::tag_t [`ISSUE_NFU-1:0] t2;
    logic [`ISSUE_NFU-1:0]            wr_row;
    issue_pkg::tag_t                  wb_tag;
    issue_pkg::tag_t                  new_t1;
    issue_pkg::tag_t                  new_t2;

    assign wb_tag = wb_fu + 2'd1;

    // a producer finishing this cycle is already resolved for the new row
    assign new_t1 = (wb_en && (disp_t1 == wb_tag)) ? '0 : disp_t1;
    assign new_t2 = (wb_en && (disp_t2 == wb_tag)) ? '0 : disp_t2;

    // a row accepts dispatch when empty or when its unit retires now
    always_comb begin
        for (int i = 0; i < `ISSUE_NFU; i++) begin
            wr_row[i] = disp_en && (disp_fu == issue_pkg::fu_idx_t'(i)) &&
                        ((state[i] == issue_pkg::FUST_EMPTY) ||
                         ((state[i] == issue_pkg::FUST_EX) && wb_en &&
                          (wb_fu == issue_pkg::fu_idx_t'(i))));
            elig[i] = ((state[i] == issue_pkg::FUST_WAIT) ||
                       (state[i] == issue_pkg::FUST_RDY)) &&
                      (t1[i] == '0) && (t2[i] == '0);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            t1   <= '0;
            t2   <= '0;
            spec <= '0;
        end else begin
            for (int i = 0; i < `ISSUE_NFU; i++) begin
                if (wr_row[i]) begin
                    t1[i]   <= new_t1;
                    t2[i]   <= new_t2;
                    spec[i] <= disp_spec;
                end else if (flush_rows[i]) begin
                    t1[i]   <= '0;
                    t2[i]   <= '0;
                    spec[i] <= 1'b0;
                end else if (wb_en) begin
                    // wakeup on writeback
                    if (t1[i] == wb_tag) t1[i] <= '0;
                    if (t2[i] == wb_tag) t2[i] <= '0;
                end
            end
        end
    end

    // register names captured at dispatch
    always_ff @(posedge CLK) begin
        for (int i = 0; i < `ISSUE_NFU; i++) begin
            if (wr_row[i]) begin
                row_rd[i]  <= disp_rd;
                row_rs1[i] <= disp_rs1;
                row_rs2[i] <= disp_rs2;
            end
        end
    end

endmodule

//--- hw/fust_age.sv
/* row age tracking */

`timescale 1ns/1ns
`include "issue_defines.svh"

module fust_age (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    disp_en,
    input  issue_pkg::fu_idx_t                      disp_fu,
    input  issue_pkg::fust_state_e [`ISSUE_NFU-1:0] state,
    input  logic [`ISSUE_NFU-1:0]                   elig,
    output logic [`ISSUE_NFU-1:0]                   oldest
);

    issue_pkg::age_t [`ISSUE_NFU-1:0] age;
    issue_pkg::age_t [`ISSUE_NFU-1:0] next_age;
    logic [`ISSUE_NFU-1:0]            disp_hit;
    issue_pkg::age_t                  best_age;
    logic                             found;

    always_comb begin
        for (int i = 0; i < `ISSUE_NFU; i++) begin
            disp_hit[i] = disp_en && (disp_fu == issue_pkg::fu_idx_t'(i));
            case (state[i])
                issue_pkg::FUST_EMPTY,
                issue_pkg::FUST_EX: next_age[i] = disp_hit[i] ? 2'd1 : 2'd0;
                // live rows grow older with every new dispatch
                default: next_age[i] = (disp_en && (age[i] != '1)) ? age[i] + 2'd1 : age[i];
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            age <= '0;
        end else begin
            age <= next_age;
        end
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin
        oldest   = '0;
        best_age = '0;
        found    = 1'b0;
        for (int i = 0; i < `ISSUE_NFU; i++) begin
            if (elig[i] && (!found || (age[i] > best_age))) begin
                found     = 1'b1;
                best_age  = age[i];
                oldest    = '0;
                oldest[i] = 1'b1;
            end
        end
    end

    // a live row always carries the age set by its dispatch
    for (genvar g = 0; g < `ISSUE_NFU; g++) begin : g_live_age
        assert property (@(posedge CLK) disable iff (!nRST)
            ((state[g] == issue_pkg::FUST_WAIT) || (state[g] == issue_pkg::FUST_RDY)) |->
                (age[g] != '0));
    end

endmodule

//--- hw/issue_fsm.sv
/* per row issue state machine */

`timescale 1ns/1ns
`include "issue_defines.svh"

module issue_fsm (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    disp_en,
    input  issue_pkg::fu_idx_t                      disp_fu,
    input  logic                                    wb_en,
    input  issue_pkg::fu_idx_t                      wb_fu,
    input  logic                                    branch_miss,
    input  logic                                    freeze,
    input  logic [`ISSUE_NFU-1:0]                   elig,
    input  logic [`ISSUE_NFU-1:0]                   oldest,
    input  logic [`ISSUE_NFU-1:0]                   spec,
    output issue_pkg::fust_state_e [`ISSUE_NFU-1:0] state,
    output logic [`ISSUE_NFU-1:0]                   issue_sel,
    output logic [`ISSUE_NFU-1:0]                   busy,
    output logic [`ISSUE_NFU-1:0]                   flush_rows
);

    issue_pkg::fust_state_e [`ISSUE_NFU-1:0] next_state;
    logic [`ISSUE_NFU-1:0]                   wb_hit;
    logic [`ISSUE_NFU-1:0]                   disp_ok;

    always_comb begin
        for (int i = 0; i < `ISSUE_NFU; i++) begin
            wb_hit[i]     = wb_en && (wb_fu == issue_pkg::fu_idx_t'(i));
            // the unit frees up in the same cycle its result comes back
            busy[i]       = (state[i] != issue_pkg::FUST_EMPTY) && !wb_hit[i];
            disp_ok[i]    = disp_en && (disp_fu == issue_pkg::fu_idx_t'(i)) && !busy[i];
            flush_rows[i] = branch_miss && spec[i] &&
                            ((state[i] == issue_pkg::FUST_WAIT) ||
                             (state[i] == issue_pkg::FUST_RDY));
        end
    end

    // a row squashed this cycle must not also go out as a packet
    assign issue_sel = freeze ? '0 : (oldest & ~flush_rows);

    always_comb begin
        next_state = state;
        for (int i = 0; i < `ISSUE_NFU; i++) begin
            case (state[i])
                issue_pkg::FUST_EMPTY: begin
                    if (disp_ok[i]) next_state[i] = issue_pkg::FUST_WAIT;
                end
                issue_pkg::FUST_WAIT,
                issue_pkg::FUST_RDY: begin
                    if (flush_rows[i]) begin
                        next_state[i] = issue_pkg::FUST_EMPTY;
                    end else if (issue_sel[i]) begin
                        next_state[i] = issue_pkg::FUST_EX;
                    end else if (elig[i] && !freeze) begin
                        // passed over by an older row
                        next_state[i] = issue_pkg::FUST_RDY;
                    end
                end
                issue_pkg::FUST_EX: begin
                    if (wb_hit[i]) begin
                        next_state[i] = disp_ok[i] ? issue_pkg::FUST_WAIT
                                                   : issue_pkg::FUST_EMPTY;
                    end
                end
                default: next_state[i] = issue_pkg::FUST_EMPTY;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `ISSUE_NFU; i++) begin
                state[i] <= issue_pkg::FUST_EMPTY;
            end
        end else begin
            state <= next_state;
        end
    end

    // results only come from units that were issued
    assert property (@(posedge CLK) disable iff (!nRST)
        wb_en |-> (state[wb_fu] == issue_pkg::FUST_EX));

    // dispatch targets a free unit, or one retiring in the same cycle
    assert property (@(posedge CLK) disable iff (!nRST)
        disp_en |-> !busy[disp_fu]);

endmodule

//--- hw/issue_stage.sv
/* out-of-order issue stage */

`timescale 1ns/1ns
`include "issue_defines.svh"

module issue_stage (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  disp_en,
    input  issue_pkg::fu_idx_t    disp_fu,
    input  issue_pkg::regbits_t   disp_rd,
    input  issue_pkg::regbits_t   disp_rs1,
    input  issue_pkg::regbits_t   disp_rs2,
    input  issue_pkg::tag_t       disp_t1,
    input  issue_pkg::tag_t       disp_t2,
    input  logic                  disp_spec,
    input  logic                  wb_en,
    input  issue_pkg::fu_idx_t    wb_fu,
    input  issue_pkg::regbits_t   wb_rd,
    input  issue_pkg::word_t      wb_data,
    input  logic                  freeze,
    input  logic                  branch_miss,
    output logic                  issue_valid,
    output issue_pkg::fu_idx_t    issue_fu,
    output issue_pkg::regbits_t   issue_rd,
    output issue_pkg::word_t      issue_rdat1,
    output issue_pkg::word_t      issue_rdat2,
    output logic [`ISSUE_NFU-1:0] busy
);

    issue_pkg::fust_state_e [`ISSUE_NFU-1:0] state;
    logic [`ISSUE_NFU-1:0]                   elig;
    logic [`ISSUE_NFU-1:0]                   oldest;
    logic [`ISSUE_NFU-1:0]                   issue_sel;
    logic [`ISSUE_NFU-1:0]                   flush_rows;
    logic [`ISSUE_NFU-1:0]                   spec;
    issue_pkg::regbits_t [`ISSUE_NFU-1:0]    row_rd;
    issue_pkg::regbits_t [`ISSUE_NFU-1:0]    row_rs1;
    issue_pkg::regbits_t [`ISSUE_NFU-1:0]    row_rs2;
    issue_pkg::regbits_t                     rsel1;
    issue_pkg::regbits_t                     rsel2;
    issue_pkg::regbits_t                     sel_rd;
    issue_pkg::fu_idx_t                      sel_fu;
    issue_pkg::word_t                        rdat1;
    issue_pkg::word_t                        rdat2;

    regfile regfile_inst (
        .CLK, .nRST, .wen(wb_en), .wsel(wb_rd), .wdata(wb_data),
        .rsel1, .rsel2, .rdat1, .rdat2
    );

    fust_table fust_table_inst (
        .CLK, .nRST, .disp_en, .disp_fu, .disp_rd, .disp_rs1, .disp_rs2,
        .disp_t1, .disp_t2, .disp_spec, .wb_en, .wb_fu, .state, .flush_rows,
        .elig, .row_rd, .row_rs1, .row_rs2, .spec
    );

    fust_age fust_age_inst (
        .CLK, .nRST, .disp_en, .disp_fu, .state, .elig, .oldest
    );

    issue_fsm issue_fsm_inst (
        .CLK, .nRST, .disp_en, .disp_fu, .wb_en, .wb_fu, .branch_miss, .freeze,
        .elig, .oldest, .spec, .state, .issue_sel, .busy, .flush_rows
    );

    // route the selected row to the read ports, issue_sel is one-hot
    always_comb begin
        rsel1  = '0;
        rsel2  = '0;
        sel_rd = '0;
        sel_fu = '0;
        for (int i = 0; i < `ISSUE_NFU; i++) begin
            if (issue_sel[i]) begin
                rsel1  = row_rs1[i];
                rsel2  = row_rs2[i];
                sel_rd = row_rd[i];
                sel_fu = issue_pkg::fu_idx_t'(i);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
        end else if (!freeze) begin
            issue_valid <= |issue_sel;
        end
    end

    // packet fields load only with a new issue
    always_ff @(posedge CLK) begin
        if (!freeze && (|issue_sel)) begin
            issue_fu    <= sel_fu;
            issue_rd    <= sel_rd;
            issue_rdat1 <= rdat1;
            issue_rdat2 <= rdat2;
        end
    end

endmodule

//--- test/issue_checker.sv
/* issue stage reference checker */

`timescale 1ns/1ns
`include "issue_defines.svh"

module issue_checker (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  disp_en,
    input  issue_pkg::fu_idx_t    disp_fu,
    input  issue_pkg::regbits_t   disp_rd,
    input  issue_pkg::regbits_t   disp_rs1,
    input  issue_pkg::regbits_t   disp_rs2,
    input  issue_pkg::tag_t       disp_t1,
    input  issue_pkg::tag_t       disp_t2,
    input  logic                  disp_spec,
    input  logic                  wb_en,
    input  issue_pkg::fu_idx_t    wb_fu,
    input  issue_pkg::regbits_t   wb_rd,
    input  issue_pkg::word_t      wb_data,
    input  logic                  freeze,
    input  logic                  branch_miss,
    input  logic                  issue_valid,
    input  issue_pkg::fu_idx_t    issue_fu,
    input  issue_pkg::regbits_t   issue_rd,
    input  issue_pkg::word_t      issue_rdat1,
    input  issue_pkg::word_t      issue_rdat2,
    input  logic [`ISSUE_NFU-1:0] busy
);

    // model of the rows, ages and register file
    issue_pkg::fust_state_e st   [`ISSUE_NFU];
    issue_pkg::tag_t        t1   [`ISSUE_NFU];
    issue_pkg::tag_t        t2   [`ISSUE_NFU];
    logic                   spec [`ISSUE_NFU];
    issue_pkg::regbits_t    rd   [`ISSUE_NFU];
    issue_pkg::regbits_t    rs1  [`ISSUE_NFU];
    issue_pkg::regbits_t    rs2  [`ISSUE_NFU];
    issue_pkg::age_t        age  [`ISSUE_NFU];
    issue_pkg::word_t       regs [`ISSUE_NREG];

    // expected registered packet
    logic                exp_valid;
    issue_pkg::fu_idx_t  exp_fu;
    issue_pkg::regbits_t exp_rd;
    issue_pkg::word_t    exp_d1;
    issue_pkg::word_t    exp_d2;

    int value_errs;
    int miss_errs;
    int packets;

    // register read as seen in this cycle, a writeback is forwarded
    function automatic issue_pkg::word_t read_reg(input issue_pkg::regbits_t r);
        if (r == '0) return '0;
        if (wb_en && (wb_rd == r)) return wb_data;
        return regs[r];
    endfunction

    task automatic check_outputs();
        logic [`ISSUE_NFU-1:0] exp_busy;
        for (int i = 0; i < `ISSUE_NFU; i++) begin
            exp_busy[i] = (st[i] != issue_pkg::FUST_EMPTY) &&
                          !(wb_en && (wb_fu == issue_pkg::fu_idx_t'(i)));
        end
        if (busy !== exp_busy) begin
            value_errs++;
            $display("Fail %0t: busy %b, expected %b", $time, busy, exp_busy);
        end
        if (exp_valid && (issue_valid !== 1'b1)) begin
            miss_errs++;
            $display("at %0t ns an issue from fu %0d was expected but none was seen",
                     $time, exp_fu);
        end else if (!exp_valid && (issue_valid !== 1'b0)) begin
            value_errs++;
            $display("Fail %0t: issue_valid %b with no issue expected", $time, issue_valid);
        end else if (exp_valid && ({issue_fu, issue_rd, issue_rdat1, issue_rdat2} !==
                                   {exp_fu, exp_rd, exp_d1, exp_d2})) begin
            value_errs++;
            $display("Fail %0t: packet fu %0d rd %0d %h %h, expected fu %0d rd %0d %h %h",
                     $time, issue_fu, issue_rd, issue_rdat1, issue_rdat2,
                     exp_fu, exp_rd, exp_d1, exp_d2);
        end
    endtask

    task automatic step_model();
        logic [`ISSUE_NFU-1:0] elig;
        logic [`ISSUE_NFU-1:0] flush;
        logic [`ISSUE_NFU-1:0] sel;
        logic [`ISSUE_NFU-1:0] hit_wb;
        logic [`ISSUE_NFU-1:0] hit_disp;
        logic [`ISSUE_NFU-1:0] disp_ok;
        issue_pkg::age_t       best;
        issue_pkg::tag_t       wtag;
        int                    pick;
        wtag = issue_pkg::tag_t'(wb_fu) + 2'd1;
        best = '0;
        pick = -1;
        sel  = '0;
        for (int i = 0; i < `ISSUE_NFU; i++) begin
            hit_wb[i]   = wb_en && (wb_fu == issue_pkg::fu_idx_t'(i));
            hit_disp[i] = disp_en && (disp_fu == issue_pkg::fu_idx_t'(i));
            disp_ok[i]  = hit_disp[i] && ((st[i] == issue_pkg::FUST_EMPTY) || hit_wb[i]);
            elig[i]  = ((st[i] == issue_pkg::FUST_WAIT) || (st[i] == issue_pkg::FUST_RDY)) &&
                       (t1[i] == '0) && (t2[i] == '0);
            flush[i] = branch_miss && spec[i] &&
                       ((st[i] == issue_pkg::FUST_WAIT) || (st[i] == issue_pkg::FUST_RDY));
            // oldest eligible row, lowest index wins a tie
            if (elig[i] && ((pick < 0) || (age[i] > best))) begin
                pick = i;
                best = age[i];
            end
        end
        if ((pick >= 0) && !freeze && !flush[pick]) sel[pick] = 1'b1;

        if (!freeze) begin
            exp_valid = |sel;
            if (|sel) begin
                exp_fu = issue_pkg::fu_idx_t'(pick);
                exp_rd = rd[pick];
                exp_d1 = read_reg(rs1[pick]);
                exp_d2 = read_reg(rs2[pick]);
                packets++;
            end
        end

        for (int i = 0; i < `ISSUE_NFU; i++) begin
            if ((st[i] == issue_pkg::FUST_EMPTY) || (st[i] == issue_pkg::FUST_EX)) begin
                age[i] = hit_disp[i] ? 2'd1 : 2'd0;
            end else if (disp_en && (age[i] != 2'd3)) begin
                age[i] = age[i] + 2'd1;
            end
            if (disp_ok[i]) begin
                t1[i]   = (wb_en && (disp_t1 == wtag)) ? '0 : disp_t1;
                t2[i]   = (wb_en && (disp_t2 == wtag)) ? '0 : disp_t2;
                spec[i] = disp_spec;
                rd[i]   = disp_rd;
                rs1[i]  = disp_rs1;
                rs2[i]  = disp_rs2;
            end else if (flush[i]) begin
                t1[i]   = '0;
                t2[i]   = '0;
                spec[i] = 1'b0;
            end else if (wb_en) begin
                if (t1[i] == wtag) t1[i] = '0;
                if (t2[i] == wtag) t2[i] = '0;
            end
            case (st[i])
                issue_pkg::FUST_EMPTY: begin
                    if (disp_ok[i]) st[i] = issue_pkg::FUST_WAIT;
                end
                issue_pkg::FUST_WAIT,
                issue_pkg::FUST_RDY: begin
                    if (flush[i]) st[i] = issue_pkg::FUST_EMPTY;
                    else if (sel[i]) st[i] = issue_pkg::FUST_EX;
                    else if (elig[i] && !freeze) st[i] = issue_pkg::FUST_RDY;
                end
                default: begin
                    if (hit_wb[i]) begin
                        st[i] = disp_ok[i] ? issue_pkg::FUST_WAIT : issue_pkg::FUST_EMPTY;
                    end
                end
            endcase
        end

        if (wb_en && (wb_rd != '0)) regs[wb_rd] = wb_data;
    endtask

    // outputs are compared before the edge, then the model steps
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `ISSUE_NFU; i++) begin
                st[i]   = issue_pkg::FUST_EMPTY;
                t1[i]   = '0;
                t2[i]   = '0;
                spec[i] = 1'b0;
                rd[i]   = '0;
                rs1[i]  = '0;
                rs2[i]  = '0;
                age[i]  = '0;
            end
            for (int r = 0; r < `ISSUE_NREG; r++) begin
                regs[r] = '0;
            end
            exp_valid = 1'b0;
        end else begin
            check_outputs();
            step_model();
        end
    end

    initial begin
        value_errs = 0;
        miss_errs  = 0;
        packets    = 0;
        exp_fu     = '0;
        exp_rd     = '0;
        exp_d1     = '0;
        exp_d2     = '0;
    end

endmodule

//--- test/tb_issue.sv
/* issue stage testbench */

`timescale 1ns/1ns
`include "issue_defines.svh"

module tb_issue;

    localparam int NCYC   = 2000;
    localparam int PERIOD = 4;

    logic                  CLK;
    logic                  nRST;
    logic                  disp_en;
    issue_pkg::fu_idx_t    disp_fu;
    issue_pkg::regbits_t   disp_rd;
    issue_pkg::regbits_t   disp_rs1;
    issue_pkg::regbits_t   disp_rs2;
    issue_pkg::tag_t       disp_t1;
    issue_pkg::tag_t       disp_t2;
    logic                  disp_spec;
    logic                  wb_en;
    issue_pkg::fu_idx_t    wb_fu;
    issue_pkg::regbits_t   wb_rd;
    issue_pkg::word_t      wb_data;
    logic                  freeze;
    logic                  branch_miss;
    logic                  issue_valid;
    issue_pkg::fu_idx_t    issue_fu;
    issue_pkg::regbits_t   issue_rd;
    issue_pkg::word_t      issue_rdat1;
    issue_pkg::word_t      issue_rdat2;
    logic [`ISSUE_NFU-1:0] busy;

    logic [31:0] rng;

    issue_stage issue_stage_inst (.*);

    issue_checker checker_inst (.*);

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // producer tag on a unit in EX that is not retiring this cycle, else zero
    function automatic issue_pkg::tag_t pick_tag(input logic [31:0] r);
        int j;
        j = int'(r[7:0]) % `ISSUE_NFU;
        if (r[8] || (checker_inst.st[j] != issue_pkg::FUST_EX) ||
            (wb_en && (int'(wb_fu) == j))) begin
            return '0;
        end
        return issue_pkg::tag_t'(j + 1);
    endfunction

    task automatic drive_cycle();
        logic [31:0] r;
        int          f;
        r = next_rand();
        freeze      = (r[2:0] == 3'd0);
        branch_miss = (r[7:4] == 4'd0);
        f = int'(r[15:8]) % `ISSUE_NFU;
        wb_en   = r[16] && (checker_inst.st[f] == issue_pkg::FUST_EX);
        wb_fu   = issue_pkg::fu_idx_t'(f);
        // low registers only, so reads hit recent writes and the bypass often
        wb_rd   = {2'b00, r[19:17]};
        wb_data = next_rand();
        r = next_rand();
        f = int'(r[7:0]) % `ISSUE_NFU;
        disp_en   = r[8] && ((checker_inst.st[f] == issue_pkg::FUST_EMPTY) ||
                             (wb_en && (int'(wb_fu) == f)));
        disp_fu   = issue_pkg::fu_idx_t'(f);
        disp_rd   = r[13:9];
        disp_rs1  = {2'b00, r[16:14]};
        disp_rs2  = {2'b00, r[19:17]};
        disp_spec = r[20];
        disp_t1   = pick_tag(next_rand());
        disp_t2   = pick_tag(next_rand());
    endtask

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        rng         = 32'd87053;
        nRST        = 1'b0;
        disp_en     = 1'b0;
        disp_fu     = '0;
        disp_rd     = '0;
        disp_rs1    = '0;
        disp_rs2    = '0;
        disp_t1     = '0;
        disp_t2     = '0;
        disp_spec   = 1'b0;
        wb_en       = 1'b0;
        wb_fu       = '0;
        wb_rd       = '0;
        wb_data     = '0;
        freeze      = 1'b0;
        branch_miss = 1'b0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        for (int c = 0; c < NCYC; c++) begin
            @(negedge CLK);
            drive_cycle();
        end
        @(negedge CLK);
        $display("errors: %0d wrong values, %0d missing issues (%0d packets checked)",
                 checker_inst.value_errs, checker_inst.miss_errs, checker_inst.packets);
        if ((checker_inst.value_errs + checker_inst.miss_errs) == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // reset, the random cycles and a margin
    initial begin
        #((NCYC + 50) * PERIOD);
        $display("watchdog expired after %0d ns, the run did not finish",
                 (NCYC + 50) * PERIOD);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
hw/issue_pkg.sv
hw/regfile.sv
hw/fust_table.sv
hw/fust_age.sv
hw/issue_fsm.sv
hw/issue_stage.sv
test/issue_checker.sv
test/tb_issue.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the issue stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_issue -o sim_issue

output=$(./obj_dir/sim_issue)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
